//--- ad5676_dac_ctrl.f
hdl/dac_cmd_pkg.sv
hdl/ad5676_pkg.sv
hdl/dac_pair_if.sv
hdl/dac_cmd_sequencer.sv
hdl/dac_value_pipe.sv
hdl/spi_frame_writer.sv
hdl/ad5676_dac_ctrl.sv
dv/spi_dac_model.sv
dv/tb_ad5676_dac_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ad5676_dac_ctrl -f ad5676_dac_ctrl.f \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}

//--- dv/tb_ad5676_dac_ctrl.sv
module tb_ad5676_dac_ctrl import dac_cmd_pkg::*, ad5676_pkg::*; ();

  localparam int WR_DELAY = 50;
  localparam int CANCEL_DELAY = 200;
  localparam int CONT_DELAY = 5;
  // Test delays, 8 frames of 48 cycles per write, margin
  localparam int WATCHDOG_CYCLES = WR_DELAY + CANCEL_DELAY + CONT_DELAY + 3 * 8 * 48 + 3000;

  logic                    clk;
  logic                    resetn;
  logic [31:0]             cmd_word;
  logic                    cmd_buf_empty;
  logic                    cmd_word_rd_en;
  logic                    trigger;
  logic                    ldac_shared;
  logic                    waiting_for_trig;
  logic                    cmd_buf_underflow;
  logic                    unexp_trig;
  logic                    cal_oob;
  logic                    dac_val_oob;
  logic [NUM_CH*ABS_W-1:0] abs_dac_val_concat;
  logic                    n_cs;
  logic                    mosi;
  logic                    ldac;
  logic                    frame_valid;
  logic [FRAME_BITS-1:0]   frame_data;
  int                      frame_count;

  logic [31:0] cmd_q [$];   // FIFO contents, head is shown
  logic [23:0] rx_q [$];    // Frames seen by the DAC model
  logic [31:0] rng;
  logic        ldac_allowed;
  logic        trig_expected;
  int          ldac_cnt;
  int          cycle;
  int          ldac_cycle;
  int          frame_cycle; // Cycle the last frame was logged
  int          cal_exp [NUM_CH];
  int          code_in [NUM_CH];

  ad5676_dac_ctrl uut (.*);

  spi_dac_model dac (.clk(clk), .n_cs(n_cs), .mosi(mosi), .frame_valid(frame_valid),
                     .frame_data(frame_data), .frame_count(frame_count));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input longint exp, input longint act);
    assert (exp == act) else report_fail($sformatf("[FAIL] %s expected %0h actual %0h",
                                                   name, exp, act));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [23:0] build_expected_frame(input int ch, input int code);
    return {4'b0001, 1'b0, ch[2:0], code[15:0]};
  endfunction

  function automatic logic [3:0] error_flags();
    return {dac_val_oob, cal_oob, unexp_trig, cmd_buf_underflow};
  endfunction

  // All words land at one edge so pairs never lag the command
  task automatic push_burst(input logic [31:0] words [$]);
    @(negedge clk);
    foreach (words[i]) cmd_q.push_back(words[i]);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    resetn  <= 1'b0;
    trigger <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    cmd_q.delete();
    rx_q.delete();
    @(posedge clk);
    resetn <= 1'b1;
  endtask

  task automatic wait_ldac(input int limit, input string what);
    int n;
    n = 0;
    while (!ldac) begin
      @(posedge clk);
      n++;
      if (n > limit) report_fail({"ldac never pulsed during ", what});
    end
    @(posedge clk); // Snapshot updated at this edge
  endtask

  task automatic expect_flag(input int idx, input string name);
    int         n;
    logic [3:0] flags;
    n = 0;
    flags = error_flags();
    while (!flags[idx]) begin
      @(posedge clk);
      n++;
      if (n > 200) report_fail({name, " was never raised"});
      flags = error_flags();
    end
  endtask

  //////////////////////////////////////////////////
  // FIFO model, DAC frame log, watchdog

  always @(posedge clk) begin
    if (cmd_word_rd_en && cmd_q.size() > 0) void'(cmd_q.pop_front());
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() > 0) ? cmd_q[0] : 32'h0;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (frame_valid) begin
      rx_q.push_back(frame_data);
      frame_cycle <= cycle;
    end
    if (ldac) begin
      ldac_cnt   <= ldac_cnt + 1;
      ldac_cycle <= cycle;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_fail("Watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////
  // Protocol checks

  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!resetn)
    cmd_buf_empty |-> !cmd_word_rd_en) else report_fail("Pop while the command FIFO was empty");
  a_ldac_single: assert property (@(posedge clk) disable iff (!resetn)
    ldac |=> !ldac) else report_fail("ldac pulse longer than one cycle");
  a_ldac_allowed: assert property (@(posedge clk) disable iff (!resetn)
    ldac |-> ldac_allowed) else report_fail("ldac pulsed when no pulse was due");
  a_trig_only_waiting: assert property (@(posedge clk) disable iff (!resetn)
    (trigger && trig_expected) |-> waiting_for_trig)
    else report_fail("Trigger arrived while the controller was not waiting");
  a_halt_quiet: assert property (@(posedge clk) disable iff (!resetn)
    (error_flags() != 4'b0) |=> (n_cs && !ldac && !cmd_word_rd_en))
    else report_fail("Controller kept running after an error flag");
  a_reset_outputs: assert property (@(posedge clk)
    !resetn |=> (n_cs && !mosi && !ldac && !waiting_for_trig && error_flags() == 4'b0))
    else report_fail("Outputs not at their reset values");

  //////////////////////////////////////////////////
  // Tests

  initial begin
    logic [31:0] w [$];
    int          n0;
    resetn        = 1'b0;
    cmd_word      = 32'h0;
    cmd_buf_empty = 1'b1;
    trigger       = 1'b0;
    ldac_shared   = 1'b0;
    ldac_allowed  = 1'b0;
    trig_expected = 1'b1;
    ldac_cnt      = 0;
    cycle         = 0;
    ldac_cycle    = 0;
    frame_cycle   = 0;
    rng           = 32'd58;
    apply_reset();

    // Calibrate every channel, then one DAC write with LDAC after a delay
    w.delete();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      rng = xorshift32(rng);
      cal_exp[ch] = int'(rng % 8193) - 4096;
      rng = xorshift32(rng);
      code_in[ch] = 12767 + int'(rng % 40001); // Never 16'hFFFF, stays in range
      w.push_back({2'b10, 11'd0, ch[2:0], cal_exp[ch][15:0]});
    end
    w.push_back({2'b01, 1'b0, 1'b0, 1'b1, 1'b0, 26'(WR_DELAY)});
    for (int k = 0; k < NUM_CH / 2; k++) begin
      w.push_back({code_in[2*k+1][15:0], code_in[2*k][15:0]});
    end
    ldac_allowed <= 1'b1;
    push_burst(w);
    wait_ldac(2000, "the DAC write");
    check_value("frame count", 8, rx_q.size());
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_value($sformatf("frame ch%0d", ch),
                  build_expected_frame(ch, code_in[ch] + cal_exp[ch]), rx_q[ch]);
      check_value($sformatf("abs ch%0d", ch), (code_in[ch] - 32767 + cal_exp[ch] < 0) ?
                  32767 - code_in[ch] - cal_exp[ch] : code_in[ch] - 32767 + cal_exp[ch],
                  abs_dac_val_concat[ch*ABS_W +: ABS_W]);
    end
    repeat (100) @(posedge clk);
    check_value("ldac pulses after write", 1, ldac_cnt);
    // Last frame, one pair_done cycle, the delay, then one cycle to ldac
    check_value("ldac delay after frames", WR_DELAY + 2, ldac_cycle - frame_cycle);

    // Trigger wait with LDAC
    w.delete();
    w.push_back({2'b00, 1'b1, 1'b0, 1'b1, 27'd0});
    push_burst(w);
    repeat (3) @(posedge clk);
    check_value("waiting_for_trig", 1, waiting_for_trig);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
    wait_ldac(10, "the trigger wait");
    check_value("ldac pulses after trigger", 2, ldac_cnt);

    // Cancel during a delay drops the LDAC pulse
    ldac_allowed <= 1'b0;
    w.delete();
    w.push_back({2'b00, 1'b0, 1'b0, 1'b1, 1'b0, 26'(CANCEL_DELAY)});
    push_burst(w);
    repeat (20) @(posedge clk);
    w.delete();
    w.push_back({2'b11, 30'd0});
    push_burst(w);
    repeat (CANCEL_DELAY + 20) @(posedge clk);
    check_value("cancel popped", 0, cmd_q.size());
    check_value("ldac pulses after cancel", 2, ldac_cnt);

    // Trigger outside a wait halts everything
    trig_expected <= 1'b0;
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
    expect_flag(1, "unexp_trig");
    w.delete();
    w.push_back({2'b01, 1'b0, 1'b0, 1'b1, 1'b0, 26'd3});
    for (int k = 0; k < 4; k++) w.push_back(32'h7FFF_7FFF);
    push_burst(w);
    repeat (150) @(posedge clk);
    check_value("no pops after halt", 5, cmd_q.size());
    apply_reset();
    trig_expected <= 1'b1;

    // Calibration out of bounds leaves the table alone
    w.delete();
    w.push_back({2'b10, 11'd0, 3'd3, 16'd100});
    w.push_back({2'b10, 11'd0, 3'd3, 16'd5000});
    push_burst(w);
    expect_flag(2, "cal_oob");
    check_value("cal ch3 kept", 100, uut.u_pipe.cal_tab[3]);
    apply_reset();

    // Forbidden input code
    w.delete();
    w.push_back({2'b01, 1'b0, 1'b0, 1'b0, 1'b0, 26'd3});
    w.push_back({16'h8000, 16'hFFFF});
    for (int k = 0; k < 3; k++) w.push_back(32'h7FFF_7FFF);
    push_burst(w);
    expect_flag(3, "dac_val_oob");
    apply_reset();

    // Continue bit with nothing queued behind it
    w.delete();
    w.push_back({2'b00, 1'b0, 1'b1, 1'b0, 1'b0, 26'(CONT_DELAY)});
    push_burst(w);
    expect_flag(0, "cmd_buf_underflow");
    apply_reset();
    n0 = frame_count;
    repeat (10) @(posedge clk);
    check_value("quiet after reset", n0, frame_count);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- dv/spi_dac_model.sv
// Passive SPI slave, collects 24-bit frames while n_cs is low
module spi_dac_model import ad5676_pkg::*; (
  input  logic                  clk,
  input  logic                  n_cs,
  input  logic                  mosi,
  output logic                  frame_valid, // One-cycle strobe per complete frame
  output logic [FRAME_BITS-1:0] frame_data,
  output int                    frame_count  // Frames seen since time zero
);

  logic [FRAME_BITS-1:0] shift;
  int                    bit_cnt;

  initial begin
    frame_valid = 1'b0;
    frame_data  = '0;
    frame_count = 0;
    shift       = '0;
    bit_cnt     = 0;
  end

  //////////////////////////////////////////////////
  // Bit capture, MSB first on rising edges

  always @(posedge clk) begin
    frame_valid <= 1'b0;
    if (!n_cs) begin
      if (bit_cnt == FRAME_BITS - 1) begin
        frame_data  <= {shift[FRAME_BITS-2:0], mosi};
        frame_valid <= 1'b1;
        frame_count <= frame_count + 1;
        bit_cnt     <= 0;
      end else begin
        bit_cnt <= bit_cnt + 1;
      end
      shift <= {shift[FRAME_BITS-2:0], mosi};
    end else begin
      bit_cnt <= 0; // Partial frame dropped when n_cs rises early
    end
  end

endmodule

//--- hdl/ad5676_dac_ctrl.sv
module ad5676_dac_ctrl import ad5676_pkg::*; (
  input  logic                    clk,
  input  logic                    resetn,
  // Show-ahead command FIFO
  input  logic [31:0]             cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  // Trigger and shared LDAC
  input  logic                    trigger,
  input  logic                    ldac_shared,
  output logic                    waiting_for_trig,
  // Sticky errors
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig,
  output logic                    cal_oob,
  output logic                    dac_val_oob,
  output logic [NUM_CH*ABS_W-1:0] abs_dac_val_concat,
  // DAC pins
  output logic                    n_cs,
  output logic                    mosi,
  output logic                    ldac
);

  logic pair_pop;  // Pair word taken from the FIFO
  logic cal_wr;    // Set-cal word at the FIFO head
  logic halt;
  logic val_fault;
  logic pair_done; // Both frames of a pair sent

  dac_pair_if pair_if ();

  dac_cmd_sequencer u_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .trigger           (trigger),
    .ldac_shared       (ldac_shared),
    .val_fault         (val_fault),
    .pair_done         (pair_done),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .pair_pop          (pair_pop),
    .cal_wr            (cal_wr),
    .ldac              (ldac),
    .halt              (halt),
    .waiting_for_trig  (waiting_for_trig),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig)
  );

  dac_value_pipe u_pipe (
    .clk                (clk),
    .resetn             (resetn),
    .cmd_word           (cmd_word),
    .pair_pop           (pair_pop),
    .cal_wr             (cal_wr),
    .ldac               (ldac),
    .halt               (halt),
    .val_fault          (val_fault),
    .cal_oob            (cal_oob),
    .dac_val_oob        (dac_val_oob),
    .abs_dac_val_concat (abs_dac_val_concat),
    .pair               (pair_if.source)
  );

  spi_frame_writer u_spi (
    .clk       (clk),
    .resetn    (resetn),
    .halt      (halt),
    .pair      (pair_if.sink),
    .pair_done (pair_done),
    .n_cs      (n_cs),
    .mosi      (mosi)
  );

endmodule

//--- hdl/spi_frame_writer.sv
module spi_frame_writer import ad5676_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      halt,
  dac_pair_if.sink  pair,
  output logic      pair_done,
  output logic      n_cs,
  output logic      mosi
);

  typedef enum logic [1:0] {
    wr_idle,  // Waiting for a pair
    wr_gap,   // n_cs high spacing
    wr_shift  // n_cs low, bits going out
  } wr_state_t;

  wr_state_t                state;
  logic                     second;    // Second frame of the pair
  logic [SPI_CNT_W-1:0]     cnt;       // Gap or bit counter
  logic [2*FRAME_BITS-1:0]  shift_reg; // Both frames, first one on top

  assign pair.taken = pair.valid && (state == wr_idle) && !halt;
  assign mosi = !n_cs && shift_reg[2*FRAME_BITS-1]; // MSB first, low between frames

  //////////////////////////////////////////////////
  // Chip select and frame sequencing

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= wr_idle;
      second    <= 1'b0;
      cnt       <= '0;
      n_cs      <= 1'b1;
      pair_done <= 1'b0;
    end else if (halt) begin
      state     <= wr_idle; // Frame in flight is dropped
      second    <= 1'b0;
      n_cs      <= 1'b1;
      pair_done <= 1'b0;
    end else begin
      pair_done <= 1'b0;
      case (state)
        wr_idle: begin
          if (pair.taken) begin
            state  <= wr_gap;
            second <= 1'b0;
            cnt    <= SPI_CNT_W'(CS_HIGH_CYCLES - 1);
          end
        end
        wr_gap: begin
          if (cnt == '0) begin
            n_cs  <= 1'b0;
            cnt   <= SPI_CNT_W'(FRAME_BITS - 1);
            state <= wr_shift;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        wr_shift: begin
          if (cnt == '0) begin
            n_cs <= 1'b1; // Frame complete
            if (second) begin
              state     <= wr_idle;
              pair_done <= 1'b1;
            end else begin
              second <= 1'b1;
              cnt    <= SPI_CNT_W'(CS_HIGH_CYCLES - 1);
              state  <= wr_gap;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // Odd channel frame rides below the even one
  always_ff @(posedge clk) begin
    if (pair.taken) begin
      shift_reg <= {spi_write_frame(pair.chan, pair.code_a),
                    spi_write_frame({pair.chan[CH_W-1:1], 1'b1}, pair.code_b)};
    end else if (state == wr_shift) begin
      shift_reg <= {shift_reg[2*FRAME_BITS-2:0], 1'b0};
    end
  end

endmodule

//--- hdl/dac_value_pipe.sv
module dac_value_pipe import dac_cmd_pkg::*, ad5676_pkg::*; (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [31:0]             cmd_word,
  input  logic                    pair_pop,
  input  logic                    cal_wr,
  input  logic                    ldac,
  input  logic                    halt,
  output logic                    val_fault,
  output logic                    cal_oob,
  output logic                    dac_val_oob,
  output logic [NUM_CH*ABS_W-1:0] abs_dac_val_concat,
  dac_pair_if.source              pair
);

  cal_t            cal_tab [NUM_CH]; // Per-channel calibration
  abs_t            abs_tab [NUM_CH]; // Last written magnitudes
  cal_t            cal_val;
  logic [CH_W-1:0] cal_ch;
  logic            cal_ok;
  code_t           code_lo;
  code_t           code_hi;
  logic            code_bad;
  logic [CH_W-2:0] pair_idx; // Wraps after the last pair, so each write starts at 0
  logic            s1_valid;
  logic            s2_valid;
  logic [CH_W-1:0] s1_chan;
  logic [CH_W-1:0] s2_chan;
  sval_t           s1_a, s1_b;
  sval_t           s2_a, s2_b;
  logic            s2_oob;

  assign cal_val  = $signed(cmd_word[CODE_W-1:0]);
  assign cal_ch   = cmd_word[CAL_CH_LSB +: CH_W];
  assign cal_ok   = (cal_val <= ABS_CAL_MAX) && (cal_val >= -ABS_CAL_MAX);
  assign code_lo  = cmd_word[CODE_W-1:0];        // Even channel
  assign code_hi  = cmd_word[2*CODE_W-1:CODE_W]; // Odd channel
  assign code_bad = (code_lo == CODE_FORBIDDEN) || (code_hi == CODE_FORBIDDEN);
  assign s2_oob   = (s2_a > sval_t'(CODE_MID)) || (s2_a < -sval_t'(CODE_MID))
                    || (s2_b > sval_t'(CODE_MID)) || (s2_b < -sval_t'(CODE_MID));
  assign val_fault = cal_oob || dac_val_oob;

  //////////////////////////////////////////////////
  // Calibration table

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CH; i++) begin
        cal_tab[i] <= '0;
      end
      cal_oob <= 1'b0;
    end else if (cal_wr) begin
      if (cal_ok) cal_tab[cal_ch] <= cal_val;
      else cal_oob <= 1'b1; // Table left as it was
    end
  end

  //////////////////////////////////////////////////
  // Stages 1 and 2, convert then add calibration

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      pair_idx <= '0;
    end else begin
      s1_valid <= pair_pop && !code_bad && !halt;
      s2_valid <= s1_valid && !halt;
      if (pair_pop) pair_idx <= pair_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pair_pop) begin
      s1_chan <= {pair_idx, 1'b0};
      s1_a    <= offset_to_signed(code_lo);
      s1_b    <= offset_to_signed(code_hi);
    end
    s2_chan <= s1_chan;
    s2_a    <= s1_a + cal_tab[s1_chan];
    s2_b    <= s1_b + cal_tab[{s1_chan[CH_W-1:1], 1'b1}];
  end

  //////////////////////////////////////////////////
  // Stage 3, range check and hand-off

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair.valid  <= 1'b0;
      dac_val_oob <= 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
        abs_tab[i] <= '0;
      end
    end else begin
      if ((pair_pop && code_bad) || (s2_valid && s2_oob)) dac_val_oob <= 1'b1;
      if (s2_valid && !s2_oob && !halt) begin
        pair.valid                              <= 1'b1;
        abs_tab[s2_chan]                        <= signed_to_abs(s2_a);
        abs_tab[{s2_chan[CH_W-1:1], 1'b1}]      <= signed_to_abs(s2_b);
      end else if (pair.taken || halt) begin
        pair.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      pair.chan   <= s2_chan;
      pair.code_a <= signed_to_offset(s2_a);
      pair.code_b <= signed_to_offset(s2_b);
    end
  end

  // Snapshot follows the LDAC pulse
  always_ff @(posedge clk) begin
    if (!resetn) begin
      abs_dac_val_concat <= '0;
    end else if (ldac) begin
      for (int i = 0; i < NUM_CH; i++) begin
        abs_dac_val_concat[i*ABS_W +: ABS_W] <= abs_tab[i];
      end
    end
  end

endmodule

//--- hdl/dac_cmd_sequencer.sv
module dac_cmd_sequencer import dac_cmd_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,
  input  logic        cmd_buf_empty,
  input  logic        trigger,
  input  logic        ldac_shared,
  input  logic        val_fault,
  input  logic        pair_done,
  output logic        cmd_word_rd_en,
  output logic        pair_pop,
  output logic        cal_wr,
  output logic        ldac,
  output logic        halt,
  output logic        waiting_for_trig,
  output logic        cmd_buf_underflow,
  output logic        unexp_trig
);

  typedef enum logic [2:0] {
    st_idle,
    st_delay,
    st_trig_wait,
    st_dac_wr,
    st_error
  } state_t;

  state_t                state;
  cmd_op_t               op;
  logic                  do_trig;   // Latched command bits
  logic                  do_cont;
  logic                  do_ldac;
  logic [DELAY_W-1:0]    delay_cnt;
  logic                  need_pair; // Writer wants the next pair word
  logic [PAIR_CNT_W-1:0] pair_cnt;
  logic                  wait_end;
  logic                  cancel_hit;
  logic                  idle_pop;
  logic                  trig_err;
  logic                  under_err;
  logic                  err_now;

  //////////////////////////////////////////////////
  // Decode and pop

  assign op = cmd_op_t'(cmd_word[OP_MSB:OP_LSB]);

  assign wait_end = ((state == st_delay) && (delay_cnt == '0))
                    || ((state == st_trig_wait) && trigger);
  // Cancel only acts on a running wait
  assign cancel_hit = ((state == st_delay) || (state == st_trig_wait))
                      && !cmd_buf_empty && (op == op_cancel);
  assign idle_pop = (state == st_idle) && !cmd_buf_empty;

  // Trigger outside a trigger wait, or shared LDAC while frames go out
  assign trig_err = (trigger && (state != st_trig_wait))
                    || (ldac_shared && (state == st_dac_wr));
  // A word is required but the FIFO has none
  assign under_err = cmd_buf_empty
                     && (((state == st_dac_wr) && need_pair) || (wait_end && do_cont));
  assign err_now = trig_err || under_err || val_fault;

  assign pair_pop = (state == st_dac_wr) && need_pair && !cmd_buf_empty && !err_now;
  assign cal_wr = idle_pop && (op == op_set_cal) && !err_now;
  assign cmd_word_rd_en = pair_pop || ((idle_pop || cancel_hit) && !err_now);

  assign halt = (state == st_error) || val_fault; // Fault flag halts at once
  assign waiting_for_trig = (state == st_trig_wait);

  //////////////////////////////////////////////////
  // Command FSM

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_idle;
      do_trig   <= 1'b0;
      do_cont   <= 1'b0;
      do_ldac   <= 1'b0;
      delay_cnt <= '0;
      need_pair <= 1'b0;
      pair_cnt  <= '0;
    end else if (err_now) begin
      state     <= st_error; // Sticky until reset
      need_pair <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!cmd_buf_empty) begin
            do_trig   <= cmd_word[TRIG_BIT];
            do_cont   <= cmd_word[CONT_BIT];
            do_ldac   <= cmd_word[LDAC_BIT];
            delay_cnt <= cmd_word[DELAY_W-1:0]; // Counted after the frames
            pair_cnt  <= '0;
            case (op)
              op_no_op:  state <= cmd_word[TRIG_BIT] ? st_trig_wait : st_delay;
              op_dac_wr: begin
                state     <= st_dac_wr;
                need_pair <= 1'b1; // First pair right after the command
              end
              default:   state <= st_idle; // Set-cal handled by the pipe
            endcase
          end
        end
        st_dac_wr: begin
          if (pair_pop) need_pair <= 1'b0;
          if (pair_done) begin
            if (pair_cnt == PAIR_CNT_W'(PAIRS_PER_WRITE - 1)) begin
              state <= do_trig ? st_trig_wait : st_delay; // All eight frames sent
            end else begin
              pair_cnt  <= pair_cnt + 1'b1;
              need_pair <= 1'b1;
            end
          end
        end
        st_delay, st_trig_wait: begin
          if (cancel_hit || wait_end) state <= st_idle;
          else if (state == st_delay) delay_cnt <= delay_cnt - 1'b1;
        end
        default: state <= st_error; // Error holds
      endcase
    end
  end

  //////////////////////////////////////////////////
  // LDAC and error flags

  always_ff @(posedge clk) begin
    if (!resetn) ldac <= 1'b0;
    else ldac <= wait_end && do_ldac && !cancel_hit && !err_now; // One-cycle pulse
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
    end else begin
      if (under_err) cmd_buf_underflow <= 1'b1;
      if (trig_err) unexp_trig <= 1'b1;
    end
  end

endmodule

//--- hdl/dac_pair_if.sv
// One calibrated channel pair, value pipe to SPI writer
interface dac_pair_if import ad5676_pkg::*; ();

  logic            valid;  // Pair ready, held until taken
  logic [CH_W-1:0] chan;   // Even channel of the pair
  code_t           code_a; // Code for chan
  code_t           code_b; // Code for chan+1
  logic            taken;  // Writer starts the pair this cycle

  modport source (
    output valid,
    output chan,
    output code_a,
    output code_b,
    input  taken
  );

  modport sink (
    input  valid,
    input  chan,
    input  code_a,
    input  code_b,
    output taken
  );

endinterface

//--- hdl/ad5676_pkg.sv
package ad5676_pkg;

  //////////////////////////////////////////////////
  // Chip and SPI frame

  localparam int NUM_CH         = 8;
  localparam int CH_W           = 3;
  localparam int CODE_W         = 16;
  localparam int ABS_W          = 15;  // Magnitude of a signed value
  localparam int FRAME_BITS     = 24;  // Cmd, zero bit, channel, code
  localparam int CONV_CYCLES    = 17;  // Conversion time in clock cycles
  // n_cs high time covers conversion and one frame length
  localparam int CS_HIGH_CYCLES = (CONV_CYCLES > FRAME_BITS) ? CONV_CYCLES : FRAME_BITS;
  localparam int SPI_CNT_W      = $clog2(CS_HIGH_CYCLES);

  localparam logic [3:0] SPI_CMD_REG_WRITE = 4'b0001; // Write input register, load on LDAC

  localparam int CODE_MID = 32767;              // Offset code of zero
  localparam logic [15:0] CODE_FORBIDDEN = 16'hFFFF;

  typedef logic [CODE_W-1:0]        code_t;
  typedef logic signed [CODE_W-1:0] cal_t;
  typedef logic [ABS_W-1:0]         abs_t;
  typedef logic signed [CODE_W:0]   sval_t;   // Signed value with calibration headroom

  //////////////////////////////////////////////////
  // Conversions

  function automatic sval_t offset_to_signed(code_t code);
    return $signed({1'b0, code}) - sval_t'(CODE_MID);
  endfunction

  function automatic code_t signed_to_offset(sval_t val);
    sval_t sum;
    sum = val + sval_t'(CODE_MID); // Range checked before this
    return sum[CODE_W-1:0];
  endfunction

  function automatic abs_t signed_to_abs(sval_t val);
    sval_t mag;
    mag = val[CODE_W] ? -val : val;
    return mag[ABS_W-1:0];
  endfunction

  function automatic logic [FRAME_BITS-1:0] spi_write_frame(logic [CH_W-1:0] ch, code_t code);
    return {SPI_CMD_REG_WRITE, 1'b0, ch, code};
  endfunction

endpackage

//--- hdl/dac_cmd_pkg.sv
package dac_cmd_pkg;

  //////////////////////////////////////////////////
  // Command opcodes

  typedef enum logic [1:0] {
    op_no_op   = 2'b00, // Delay or trigger wait
    op_dac_wr  = 2'b01, // Four pair words follow
    op_set_cal = 2'b10, // One channel calibration
    op_cancel  = 2'b11  // Ends a delay or trigger wait, no LDAC
  } cmd_op_t;

  //////////////////////////////////////////////////
  // Command word layout

  localparam int OP_MSB   = 31;
  localparam int OP_LSB   = 30;
  localparam int TRIG_BIT = 29; // Wait for trigger instead of delay
  localparam int CONT_BIT = 28; // Next command must already be queued
  localparam int LDAC_BIT = 27; // Pulse LDAC when the wait ends

  // Delay count sits in the low bits
  localparam int DELAY_W = 26;

  // Set-cal layout, channel above a 16-bit signed value
  localparam int CAL_CH_LSB = 16;

  // Largest calibration magnitude accepted
  localparam int ABS_CAL_MAX = 4096;

  //////////////////////////////////////////////////
  // DAC write payload

  // Pair words after each DAC write command
  localparam int PAIRS_PER_WRITE = 4;

  // Pair counter in the sequencer
  localparam int PAIR_CNT_W = $clog2(PAIRS_PER_WRITE);

endpackage
